/* Makefile */
# Verilator build and run of the core testbench

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module coreTb -f list.f
	./obj_dir/VcoreTb > sim.log 2>&1; status=$$?; cat sim.log; test $$status -eq 0
	! grep -q "Checks failed" sim.log

clean:
	rm -rf obj_dir sim.log

/* list.f */
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/controlDecoder.sv
logic/regFile.sv
logic/aluUnit.sv
logic/nextPcUnit.sv
logic/loadStoreUnit.sv
logic/mipsCore.sv
tb/core_assertions.sv
tb/coreTb.sv

/* logic/aluUnit.sv */
`default_nettype none

module aluUnit (
	input var isaPkg::word a,
	input var isaPkg::word b,
	input var isaPkg::imm16 imm,
	input var ctrlPkg::ctrlWord ctrl,
	output isaPkg::word result
);

	isaPkg::word immExt;
	isaPkg::word opB;

	// Sign or zero fill of the immediate
	assign immExt = ctrl.signExt ? {{16{imm[15]}}, imm} : {16'h0000, imm};

	assign opB = (ctrl.aluSrc == ctrlPkg::Imm) ? immExt : b;

	//////////////////////////////
	// Operations
	//////////////////////////////

	always_comb begin
		case (ctrl.aluOp)
			ctrlPkg::Add: begin
				result = a + opB;
			end
			ctrlPkg::Sub: begin
				result = a - opB;
			end
			ctrlPkg::Or: begin
				result = a | opB;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/controlDecoder.sv */
`default_nettype none

module controlDecoder (
	input var isaPkg::opcode op,
	input var isaPkg::funct fn,
	output ctrlPkg::ctrlWord ctrl
);

	logic isR;
	logic isAdd;
	logic isSub;
	logic isJr;
	logic isOri;
	logic isLw;
	logic isSw;
	logic isBeq;
	logic isLui;
	logic isJal;
	logic isJ;
	logic isLwwr;

	//////////////////////////////
	// Instruction recognition
	//////////////////////////////

	assign isR = (op == isaPkg::OpR);
	// Function field only matters inside R-type
	assign isAdd = isR && (fn == isaPkg::FnAdd);
	assign isSub = isR && (fn == isaPkg::FnSub);
	assign isJr = isR && (fn == isaPkg::FnJr);

	assign isOri = (op == isaPkg::OpOri);
	assign isLw = (op == isaPkg::OpLw);
	assign isSw = (op == isaPkg::OpSw);
	assign isBeq = (op == isaPkg::OpBeq);
	assign isLui = (op == isaPkg::OpLui);
	assign isJal = (op == isaPkg::OpJal);
	assign isJ = (op == isaPkg::OpJ);
	assign isLwwr = (op == isaPkg::OpLwwr);

	//////////////////////////////
	// Field assembly
	//////////////////////////////

	always_comb begin
		// Unknown codes fall out as a no-op
		ctrl = ctrlPkg::CtrlNop;

		if (isJal)
			ctrl.regDst = ctrlPkg::Link;
		else if (isAdd || isSub)
			ctrl.regDst = ctrlPkg::Rd;

		ctrl.regWrite = isAdd || isSub || isOri || isLw || isLui || isJal || isLwwr;

		// Address offsets are signed while ori stays zero-filled
		ctrl.signExt = isLw || isSw || isLwwr;

		if (isOri || isLw || isSw || isLui || isLwwr)
			ctrl.aluSrc = ctrlPkg::Imm;

		if (isOri)
			ctrl.aluOp = ctrlPkg::Or;
		else if (isSub)
			ctrl.aluOp = ctrlPkg::Sub;

		ctrl.memWrite = isSw;

		if (isLw || isLwwr)
			ctrl.wbSel = ctrlPkg::Mem;
		else if (isJal)
			ctrl.wbSel = ctrlPkg::PcLink;
		else if (isLui)
			ctrl.wbSel = ctrlPkg::Upper;

		if (isJ || isJal)
			ctrl.npc = ctrlPkg::Jump;
		else if (isBeq)
			ctrl.npc = ctrlPkg::Branch;
		else if (isJr)
			ctrl.npc = ctrlPkg::Reg;

		if (isLwwr)
			ctrl.dm = ctrlPkg::Reversed;
	end

endmodule

`default_nettype wire

/* logic/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

	//////////////////////////////
	// Select field encodings
	//////////////////////////////

	// Destination register
	typedef enum logic [1:0] {
		Rt = 2'b00,
		Rd = 2'b01,
		Link = 2'b10
	} regDstSel;

	// Second ALU operand
	typedef enum logic [1:0] {
		RegB = 2'b00,
		Imm = 2'b01
	} aluSrcSel;

	typedef enum logic [2:0] {
		Add = 3'b000,
		Sub = 3'b001,
		Or = 3'b010
	} aluOpSel;

	// Write-back source
	typedef enum logic [1:0] {
		Alu = 2'b00,
		Mem = 2'b01,
		PcLink = 2'b10,
		Upper = 2'b11
	} wbSrcSel;

	typedef enum logic [1:0] {
		Seq = 2'b00,
		Jump = 2'b01,
		Branch = 2'b10,
		Reg = 2'b11
	} npcSel;

	// Only equality for now
	typedef enum logic [2:0] {
		Eq = 3'b000
	} cmpOp;

	typedef enum logic [1:0] {
		Word = 2'b00,
		Reversed = 2'b11
	} dmOp;

	//////////////////////////////
	// Control word
	//////////////////////////////

	typedef struct packed {
		regDstSel regDst;
		logic regWrite;
		logic signExt;
		aluSrcSel aluSrc;
		aluOpSel aluOp;
		logic memWrite;
		wbSrcSel wbSel;
		npcSel npc;
		cmpOp cmp;
		dmOp dm;
	} ctrlWord;

	// No write or store and a sequential pc
	localparam ctrlWord CtrlNop = '{
		regDst: Rt,
		regWrite: 1'b0,
		signExt: 1'b0,
		aluSrc: RegB,
		aluOp: Add,
		memWrite: 1'b0,
		wbSel: Alu,
		npc: Seq,
		cmp: Eq,
		dm: Word
	};

endpackage

`default_nettype wire

/* logic/isaPkg.sv */
`default_nettype none

package isaPkg;

	//////////////////////////////
	// Field widths
	//////////////////////////////

	localparam int WordWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam int OpWidth = 6;
	localparam int FnWidth = 6;
	localparam int ImmWidth = 16;
	localparam int TargetWidth = 26;
	localparam int NumRegs = 32;

	typedef logic [WordWidth-1:0] word;
	typedef logic [RegAddrWidth-1:0] regAddr;
	typedef logic [OpWidth-1:0] opcode;
	typedef logic [FnWidth-1:0] funct;
	typedef logic [ImmWidth-1:0] imm16;

	//////////////////////////////
	// Opcodes in bits 31..26
	//////////////////////////////

	localparam opcode OpR = 6'b000000;
	localparam opcode OpOri = 6'b001101;
	localparam opcode OpLw = 6'b100011;
	localparam opcode OpSw = 6'b101011;
	localparam opcode OpBeq = 6'b000100;
	localparam opcode OpLui = 6'b001111;
	localparam opcode OpJal = 6'b000011;
	localparam opcode OpJ = 6'b000010;
	// Custom byte-reversed load
	localparam opcode OpLwwr = 6'b111111;

	// R-type function codes
	localparam funct FnAdd = 6'b100000;
	localparam funct FnSub = 6'b100010;
	localparam funct FnJr = 6'b001000;

	localparam regAddr LinkReg = 5'd31;
	localparam word ResetPc = 32'h0000_0000;

endpackage

`default_nettype wire

/* logic/loadStoreUnit.sv */
`default_nettype none

module loadStoreUnit (
	input var ctrlPkg::ctrlWord ctrl,
	input var isaPkg::word aluResult,
	input var isaPkg::word storeData,
	input var isaPkg::word readData,
	input var isaPkg::word pcPlus4,
	input var isaPkg::imm16 imm,
	input var isaPkg::regAddr rt,
	input var isaPkg::regAddr rd,
	output isaPkg::word dataAddr,
	output isaPkg::word writeData,
	output logic memWrite,
	output isaPkg::regAddr wbAddr,
	output isaPkg::word wbData,
	output logic regWrite
);

	isaPkg::word loadData;

	// Memory port
	assign dataAddr = aluResult;
	assign writeData = storeData;
	assign memWrite = ctrl.memWrite;

	// lwwr swaps byte order end to end
	assign loadData = (ctrl.dm == ctrlPkg::Reversed) ?
		{readData[7:0], readData[15:8], readData[23:16], readData[31:24]} : readData;

	//////////////////////////////
	// Write-back
	//////////////////////////////

	assign regWrite = ctrl.regWrite;

	always_comb begin
		case (ctrl.wbSel)
			ctrlPkg::Mem: wbData = loadData;
			ctrlPkg::PcLink: wbData = pcPlus4;
			ctrlPkg::Upper: wbData = {imm, 16'h0000};
			default: wbData = aluResult;
		endcase

		case (ctrl.regDst)
			ctrlPkg::Rd: wbAddr = rd;
			ctrlPkg::Link: wbAddr = isaPkg::LinkReg;
			default: wbAddr = rt;
		endcase
	end

endmodule

`default_nettype wire

/* logic/mipsCore.sv */
`default_nettype none

module mipsCore (
	input var logic clk,
	input var logic rstN,

	// Instruction port
	output isaPkg::word pc,
	input var isaPkg::word instr,

	// Data port
	output isaPkg::word dataAddr,
	output isaPkg::word writeData,
	output logic memWrite,
	input var isaPkg::word readData,

	// Retire trace mirrors the register write
	output logic regWrite,
	output isaPkg::regAddr wbAddr,
	output isaPkg::word wbData
);

	//////////////////////////////
	// Instruction fields
	//////////////////////////////

	isaPkg::opcode op;
	isaPkg::funct fn;
	isaPkg::regAddr rs;
	isaPkg::regAddr rt;
	isaPkg::regAddr rd;
	isaPkg::imm16 imm;
	logic [isaPkg::TargetWidth-1:0] target;

	assign op = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign fn = instr[5:0];
	assign imm = instr[15:0];
	assign target = instr[25:0];

	ctrlPkg::ctrlWord ctrl;
	isaPkg::word regA;
	isaPkg::word regB;
	isaPkg::word aluResult;
	isaPkg::word pcPlus4;

	//////////////////////////////
	// Blocks
	//////////////////////////////

	controlDecoder uDecoder (
		.op(op),
		.fn(fn),
		.ctrl(ctrl)
	);

	regFile uRegFile (
		.clk(clk),
		.rstN(rstN),
		.rsAddr(rs),
		.rtAddr(rt),
		.wrAddr(wbAddr),
		.wrEn(regWrite),
		.wrData(wbData),
		.rsData(regA),
		.rtData(regB)
	);

	aluUnit uAlu (
		.a(regA),
		.b(regB),
		.imm(imm),
		.ctrl(ctrl),
		.result(aluResult)
	);

	nextPcUnit uNextPc (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.a(regA),
		.b(regB),
		.imm(imm),
		.target(target),
		.pc(pc),
		.pcPlus4(pcPlus4)
	);

	// Also picks the write-back value and destination
	loadStoreUnit uLoadStore (
		.ctrl(ctrl),
		.aluResult(aluResult),
		.storeData(regB),
		.readData(readData),
		.pcPlus4(pcPlus4),
		.imm(imm),
		.rt(rt),
		.rd(rd),
		.dataAddr(dataAddr),
		.writeData(writeData),
		.memWrite(memWrite),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.regWrite(regWrite)
	);

endmodule

`default_nettype wire

/* logic/nextPcUnit.sv */
`default_nettype none

module nextPcUnit (
	input var logic clk,
	input var logic rstN,
	input var ctrlPkg::ctrlWord ctrl,
	input var isaPkg::word a,
	input var isaPkg::word b,
	input var isaPkg::imm16 imm,
	input var logic [isaPkg::TargetWidth-1:0] target,
	output isaPkg::word pc,
	output isaPkg::word pcPlus4
);

	isaPkg::word branchOffset;
	isaPkg::word pcNext;
	logic taken;

	assign pcPlus4 = pc + 32'd4;

	// Word offset relative to the following instruction
	assign branchOffset = {{14{imm[15]}}, imm, 2'b00};

	//////////////////////////////
	// Branch compare
	//////////////////////////////

	always_comb begin
		case (ctrl.cmp)
			ctrlPkg::Eq: taken = (a == b);
			default: taken = 1'b0;
		endcase
	end

	//////////////////////////////
	// Next address
	//////////////////////////////

	always_comb begin
		case (ctrl.npc)
			ctrlPkg::Jump: pcNext = {pcPlus4[31:28], target, 2'b00};
			ctrlPkg::Branch: pcNext = taken ? (pcPlus4 + branchOffset) : pcPlus4;
			ctrlPkg::Reg: pcNext = a;
			default: pcNext = pcPlus4;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= isaPkg::ResetPc;
		end else begin
			pc <= pcNext;
		end
	end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`default_nettype none

module regFile (
	input var logic clk,
	input var logic rstN,
	input var isaPkg::regAddr rsAddr,
	input var isaPkg::regAddr rtAddr,
	input var isaPkg::regAddr wrAddr,
	input var logic wrEn,
	input var isaPkg::word wrData,
	output isaPkg::word rsData,
	output isaPkg::word rtData
);

	isaPkg::word regs [isaPkg::NumRegs];

	//////////////////////////////
	// Write port
	//////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < isaPkg::NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin
			// Register zero never takes a write
			regs[wrAddr] <= wrData;
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////

	// Combinational reads without bypass of a same-cycle write
	assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

`default_nettype wire

/* tb/coreTb.sv */
`default_nettype none

module coreTb;

	localparam int ClkPeriod = 8;
	localparam int ResetCycles = 2;
	localparam int TestCycles = 400;
	localparam int NumTests = 6;
	localparam logic [31:0] Seed = 32'h5a3c;

	logic clk;
	logic rstN;
	isaPkg::word pc;
	isaPkg::word instr;
	isaPkg::word dataAddr;
	isaPkg::word writeData;
	isaPkg::word readData;
	logic memWrite;
	logic regWrite;
	isaPkg::regAddr wbAddr;
	isaPkg::word wbData;

	// Memories seen by the DUT
	isaPkg::word imem [256];
	isaPkg::word dmem [64];

	// Reference model state
	isaPkg::word refMem [64];
	isaPkg::word modelRegs [32];
	isaPkg::word modelPc;

	// Store seen on the DUT port and committed at the next edge
	logic stWr;
	logic [5:0] stIdx;
	isaPkg::word stData;

	int testErrors;
	int testsPassed;
	int testsFailed;

	mipsCore uut (
		.clk(clk),
		.rstN(rstN),
		.pc(pc),
		.instr(instr),
		.dataAddr(dataAddr),
		.writeData(writeData),
		.memWrite(memWrite),
		.readData(readData),
		.regWrite(regWrite),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

	bind controlDecoder core_assertions ctrlChecks (
		.clk(coreTb.clk),
		.rstN(coreTb.rstN),
		.ctrl(ctrl)
	);

	// Combinational reads with instr held at zero in reset
	assign instr = rstN ? imem[pc[9:2]] : '0;
	assign readData = dmem[dataAddr[7:2]];

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(NumTests * (TestCycles + ResetCycles + 2) * ClkPeriod + 100);
		$display("Watchdog expired before the tests finished");
		$display("Checks failed");
		$finish;
	end

	//////////////////////////////
	// Program generation
	//////////////////////////////

	// Three in four picks land in r0..r7
	function automatic isaPkg::regAddr pickReg();
		isaPkg::word r;
		r = $urandom;
		if (r[1:0] != 2'b00)
			return {2'b00, r[4:2]};
		return r[6:2];
	endfunction

	function automatic isaPkg::word randomInstr();
		isaPkg::word r;
		isaPkg::word ins;
		isaPkg::regAddr rs;
		isaPkg::regAddr rt;
		isaPkg::regAddr rd;
		isaPkg::opcode op;
		isaPkg::funct fn;
		int kind;
		r = $urandom;
		rs = pickReg();
		rt = pickReg();
		rd = pickReg();
		kind = $urandom_range(11, 0);
		case (kind)
			0: ins = {isaPkg::OpR, rs, rt, rd, 5'd0, isaPkg::FnAdd};
			1: ins = {isaPkg::OpR, rs, rt, rd, 5'd0, isaPkg::FnSub};
			2: ins = {isaPkg::OpR, rs, 15'd0, isaPkg::FnJr};
			3: ins = {isaPkg::OpOri, rs, rt, r[15:0]};
			4: ins = {isaPkg::OpLw, rs, rt, r[15:0]};
			5: ins = {isaPkg::OpSw, rs, rt, r[15:0]};
			6: ins = {isaPkg::OpLwwr, rs, rt, r[15:0]};
			7: begin
				// Equal registers now and then so branches get taken
				if (r[17])
					rt = rs;
				ins = {isaPkg::OpBeq, rs, rt, r[15:0]};
			end
			8: ins = {isaPkg::OpLui, 5'd0, rt, r[15:0]};
			9: ins = {isaPkg::OpJ, r[25:0]};
			10: ins = {isaPkg::OpJal, r[25:0]};
			default: begin
				op = r[31:26];
				fn = r[5:0];
				if (fn inside {isaPkg::FnAdd, isaPkg::FnSub, isaPkg::FnJr})
					fn = 6'b000001;
				if (op inside {isaPkg::OpR, isaPkg::OpOri, isaPkg::OpLw, isaPkg::OpSw,
						isaPkg::OpBeq, isaPkg::OpLui, isaPkg::OpJal, isaPkg::OpJ,
						isaPkg::OpLwwr})
					op = 6'b010000;
				// Bad R-type function or bad opcode
				ins = r[16] ? {isaPkg::OpR, rs, rt, rd, 5'd0, fn} : {op, r[25:0]};
			end
		endcase
		return ins;
	endfunction

	task automatic loadTest();
		isaPkg::word w;
		for (int i = 0; i < 256; i++) begin
			imem[i] = randomInstr();
		end
		for (int i = 0; i < 64; i++) begin
			w = $urandom;
			refMem[i] = w;
			dmem[i] <= w;
		end
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		modelPc = isaPkg::ResetPc;
		stWr = 1'b0;
		testErrors = 0;
	endtask

	//////////////////////////////
	// Reference model and checks
	//////////////////////////////

	task automatic compareWord(input string name, input isaPkg::word got,
			input isaPkg::word exp);
		assert (got === exp) else begin
			$display("ERR %s: got %h, expected %h, model pc %h", name, got, exp, modelPc);
			testErrors++;
		end
	endtask

	task automatic checkCycle();
		isaPkg::word ins;
		isaPkg::word a;
		isaPkg::word b;
		isaPkg::word sext;
		isaPkg::word zext;
		isaPkg::word link;
		isaPkg::word nextPc;
		isaPkg::word addr;
		isaPkg::word memWord;
		isaPkg::word expData;
		isaPkg::regAddr expAddr;
		logic expWr;
		logic expSt;

		ins = imem[modelPc[9:2]];
		a = modelRegs[ins[25:21]];
		b = modelRegs[ins[20:16]];
		sext = {{16{ins[15]}}, ins[15:0]};
		zext = {16'h0000, ins[15:0]};
		link = modelPc + 32'd4;
		nextPc = link;
		addr = a + sext;
		memWord = refMem[addr[7:2]];
		expData = '0;
		expAddr = ins[20:16];
		expWr = 1'b0;
		expSt = 1'b0;

		case (ins[31:26])
			isaPkg::OpR: begin
				if (ins[5:0] == isaPkg::FnAdd || ins[5:0] == isaPkg::FnSub) begin
					expWr = 1'b1;
					expAddr = ins[15:11];
					expData = (ins[5:0] == isaPkg::FnAdd) ? a + b : a - b;
				end else if (ins[5:0] == isaPkg::FnJr) begin
					nextPc = a;
				end
			end
			isaPkg::OpOri: begin
				expWr = 1'b1;
				expData = a | zext;
			end
			isaPkg::OpLw: begin
				expWr = 1'b1;
				expData = memWord;
			end
			isaPkg::OpLwwr: begin
				expWr = 1'b1;
				for (int k = 0; k < 4; k++) begin
					expData[8*k +: 8] = memWord[8*(3-k) +: 8];
				end
			end
			isaPkg::OpSw: expSt = 1'b1;
			isaPkg::OpBeq: begin
				if (a == b)
					nextPc = link + (sext << 2);
			end
			isaPkg::OpLui: begin
				expWr = 1'b1;
				expData = {ins[15:0], 16'h0000};
			end
			isaPkg::OpJ: nextPc = {link[31:28], ins[25:0], 2'b00};
			isaPkg::OpJal: begin
				expWr = 1'b1;
				expAddr = 5'd31;
				expData = link;
				nextPc = {link[31:28], ins[25:0], 2'b00};
			end
			default: ;
		endcase

		compareWord("pc", pc, modelPc);
		compareWord("regWrite", {31'd0, regWrite}, {31'd0, expWr});
		if (expWr) begin
			compareWord("wbAddr", {27'd0, wbAddr}, {27'd0, expAddr});
			compareWord("wbData", wbData, expData);
		end
		compareWord("memWrite", {31'd0, memWrite}, {31'd0, expSt});
		if (expSt) begin
			compareWord("dataAddr", dataAddr, addr);
			compareWord("writeData", writeData, b);
		end

		// r0 stays zero in the model
		if (expWr && expAddr != 5'd0)
			modelRegs[expAddr] = expData;
		if (expSt)
			refMem[addr[7:2]] = b;
		modelPc = nextPc;

		stWr = memWrite;
		stIdx = dataAddr[7:2];
		stData = writeData;
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		void'($urandom(Seed));
		rstN = 1'b0;
		testsPassed = 0;
		testsFailed = 0;
		for (int i = 0; i < 64; i++) begin
			dmem[i] <= '0;
		end
		for (int t = 0; t < NumTests; t++) begin
			@(posedge clk);
			rstN <= 1'b0;
			@(negedge clk);
			loadTest();
			repeat (ResetCycles) @(posedge clk);
			rstN <= 1'b1;
			repeat (TestCycles) begin
				@(negedge clk);
				checkCycle();
				@(posedge clk);
				if (stWr)
					dmem[stIdx] <= stData;
			end
			if (testErrors == 0) begin
				$display("test %0d: %0d cycles, no errors", t, TestCycles);
				testsPassed++;
			end else begin
				$display("test %0d: %0d cycles, %0d errors", t, TestCycles, testErrors);
				testsFailed++;
			end
		end
		$display("tests passed %0d, tests failed %0d", testsPassed, testsFailed);
		if (testsFailed == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/core_assertions.sv */
`default_nettype none

module core_assertions (
	input var logic clk,
	input var logic rstN,
	input var ctrlPkg::ctrlWord ctrl
);

	//////////////////////////////
	// Control word rules
	//////////////////////////////

	// A store never writes a register
	storeNoRegWrite: assert property (
		@(posedge clk) disable iff (!rstN) !(ctrl.memWrite && ctrl.regWrite)
	) else $error("memWrite and regWrite high together");

	// Store address always comes from base plus offset
	storeUsesImm: assert property (
		@(posedge clk) disable iff (!rstN) ctrl.memWrite |-> (ctrl.aluSrc == ctrlPkg::Imm)
	) else $error("store without the immediate operand source");

	// Jumps and branches never store
	flowNoStore: assert property (
		@(posedge clk) disable iff (!rstN) (ctrl.npc != ctrlPkg::Seq) |-> !ctrl.memWrite
	) else $error("store on a non-sequential next pc");

endmodule

`default_nettype wire
